// File: source/tlb_pkg.sv
/*
 * Shared sizes and packed types of the TLB.
 * Modules reference these through tlb_pkg:: scoped names.
 */
package tlb_pkg;

    // number of entries, kept a power of two for the PLRU tree
    localparam int unsigned TlbEntries  = 16;
    localparam int unsigned TlbIdxWidth = $clog2(TlbEntries);

    // page number widths
    localparam int unsigned VpnWidth = 20;
    localparam int unsigned PpnWidth = 22;

    // one stored translation, 43 bits
    typedef struct packed {
        logic                valid;
        logic [VpnWidth-1:0] vpn;
        logic [PpnWidth-1:0] ppn;
    } tlb_entry_t;

    // lookup strobe with the page to translate
    typedef struct packed {
        logic                valid;
        logic [VpnWidth-1:0] vpn;
    } lookup_req_t;

    // registered answer, one cycle after the strobe
    typedef struct packed {
        logic                valid;
        logic                hit;
        logic [PpnWidth-1:0] ppn;
    } lookup_rsp_t;

    // fill strobe carrying a full translation
    typedef struct packed {
        logic                valid;
        logic [VpnWidth-1:0] vpn;
        logic [PpnWidth-1:0] ppn;
    } fill_req_t;

endpackage

// File: source/plru_tree.sv
/*
 * Pseudo LRU tree over ENTRIES ways, ENTRIES a power of two.
 * Feed a one-hot use vector; plru_o names the one-hot replacement candidate.
 */
module plru_tree #(
    parameter int unsigned ENTRIES = 16
) (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic [ENTRIES-1:0] used_i,
    output logic [ENTRIES-1:0] plru_o
);

    // depth of the tree, one level per index bit
    localparam int unsigned LogEntries = $clog2(ENTRIES);

    // one bit per inner node, level by level from the root
    // node n has children 2n+1 (bit 0) and 2n+2 (bit 1)
    logic [ENTRIES-2:0] tree_q;
    logic [ENTRIES-2:0] tree_d;

    // path update on a use
    always_comb begin : tree_update
        int unsigned node;
        int unsigned shift;
        logic        dir;
        tree_d = tree_q;
        node   = 0;
        shift  = 0;
        dir    = 1'b0;
        for (int unsigned i = 0; i < ENTRIES; i++) begin
            if (used_i[i]) begin
                for (int unsigned lvl = 0; lvl < LogEntries; lvl++) begin
                    // first node of this level plus the prefix of i above it
                    shift = LogEntries - lvl;
                    node  = ((1 << lvl) - 1) + (i >> shift);
                    // index bit that picks the branch at this level, MSB at root
                    dir   = 1'((i >> (shift - 1)) & 1);
                    // point the node at the other branch
                    tree_d[node] = ~dir;
                end
            end
        end
    end

    // decode the tree into a one-hot candidate
    always_comb begin : tree_decode
        int unsigned node;
        int unsigned shift;
        logic        dir;
        plru_o = '1;
        node   = 0;
        shift  = 0;
        dir    = 1'b0;
        for (int unsigned i = 0; i < ENTRIES; i++) begin
            for (int unsigned lvl = 0; lvl < LogEntries; lvl++) begin
                shift = LogEntries - lvl;
                node  = ((1 << lvl) - 1) + (i >> shift);
                dir   = 1'((i >> (shift - 1)) & 1);
                // entry i survives only if every node on its path points its way
                if (tree_q[node] != dir) begin
                    plru_o[i] = 1'b0;
                end
            end
        end
    end

    // all zeros after reset, so entry 0 is the first candidate
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            tree_q <= '0;
        end else begin
            tree_q <= tree_d;
        end
    end

endmodule

// File: source/tlb_entry_store.sv
/*
 * Entry registers of the TLB with the CAM compare for fill and lookup.
 * The lookup answer is registered and comes out one cycle after the strobe.
 */
module tlb_entry_store (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  tlb_pkg::lookup_req_t                lookup_i,
    input  tlb_pkg::fill_req_t                  fill_i,
    input  logic                                flush_i,
    input  logic [tlb_pkg::TlbEntries-1:0]      write_en_i,
    output logic [tlb_pkg::TlbEntries-1:0]      valid_o,
    output logic [tlb_pkg::TlbEntries-1:0]      fill_match_o,
    output logic [tlb_pkg::TlbEntries-1:0]      lookup_hit_o,
    output tlb_pkg::lookup_rsp_t                lookup_o
);

    tlb_pkg::tlb_entry_t entries_q [tlb_pkg::TlbEntries];

    // translation picked by the hit vector
    logic [tlb_pkg::PpnWidth-1:0] hit_ppn;

    // registered response
    logic                         rsp_valid_q;
    logic                         rsp_hit_q;
    logic [tlb_pkg::PpnWidth-1:0] rsp_ppn_q;

    // compare both page numbers against every valid entry
    always_comb begin : match
        for (int unsigned i = 0; i < tlb_pkg::TlbEntries; i++) begin
            valid_o[i]      = entries_q[i].valid;
            fill_match_o[i] = entries_q[i].valid && (entries_q[i].vpn == fill_i.vpn);
            // hit only counts while the lookup strobe is up
            lookup_hit_o[i] = lookup_i.valid && entries_q[i].valid
                              && (entries_q[i].vpn == lookup_i.vpn);
        end
    end

    // and-or mux, hit vector is one-hot
    always_comb begin : ppn_select
        hit_ppn = '0;
        for (int unsigned i = 0; i < tlb_pkg::TlbEntries; i++) begin
            hit_ppn |= {tlb_pkg::PpnWidth{lookup_hit_o[i]}} & entries_q[i].ppn;
        end
    end

    // entry array
    // flush clears every valid bit and beats a fill in the same cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int unsigned i = 0; i < tlb_pkg::TlbEntries; i++) begin
                entries_q[i] <= '0;
            end
        end else if (flush_i) begin
            for (int unsigned i = 0; i < tlb_pkg::TlbEntries; i++) begin
                entries_q[i].valid <= 1'b0;
            end
        end else begin
            for (int unsigned i = 0; i < tlb_pkg::TlbEntries; i++) begin
                if (write_en_i[i]) begin
                    entries_q[i] <= '{valid: 1'b1, vpn: fill_i.vpn, ppn: fill_i.ppn};
                end
            end
        end
    end

    // response strobe, one cycle per lookup
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= lookup_i.valid;
        end
    end

    // hit and ppn sampled from the contents before this edge
    always_ff @(posedge clk_i) begin
        rsp_hit_q <= |lookup_hit_o;
        rsp_ppn_q <= hit_ppn;
    end

    assign lookup_o = '{valid: rsp_valid_q, hit: rsp_hit_q, ppn: rsp_ppn_q};

endmodule

// File: source/tlb_victim_sel.sv
/*
 * Combinational fill target choice and PLRU use vector for the TLB.
 * Order is matching entry, then lowest invalid entry, then the tree candidate.
 */
module tlb_victim_sel (
    input  logic                           fill_valid_i,
    input  logic                           flush_i,
    input  logic [tlb_pkg::TlbEntries-1:0] valid_i,
    input  logic [tlb_pkg::TlbEntries-1:0] fill_match_i,
    input  logic [tlb_pkg::TlbEntries-1:0] lookup_hit_i,
    input  logic [tlb_pkg::TlbEntries-1:0] plru_i,
    output logic [tlb_pkg::TlbEntries-1:0] write_en_o,
    output logic [tlb_pkg::TlbEntries-1:0] used_o
);

    logic [tlb_pkg::TlbIdxWidth-1:0] free_idx;
    logic                            free_found;
    logic [tlb_pkg::TlbEntries-1:0]  free_onehot;
    logic [tlb_pkg::TlbEntries-1:0]  target;

    // priority encoder, scan from the top so the lowest free index wins
    always_comb begin : free_search
        free_idx   = '0;
        free_found = 1'b0;
        for (int i = tlb_pkg::TlbEntries - 1; i >= 0; i--) begin
            if (!valid_i[i]) begin
                free_idx   = i[tlb_pkg::TlbIdxWidth-1:0];
                free_found = 1'b1;
            end
        end
        free_onehot           = '0;
        free_onehot[free_idx] = free_found;
    end

    always_comb begin : pick
        // same page already present, overwrite in place
        if (|fill_match_i) begin
            target = fill_match_i;
        end else if (free_found) begin
            target = free_onehot;
        end else begin
            // buffer full, evict the pseudo LRU way
            target = plru_i;
        end

        write_en_o = (fill_valid_i && !flush_i) ? target : '0;

        // fill takes the tree update, a lone lookup hit otherwise
        if (flush_i) begin
            used_o = '0;
        end else if (fill_valid_i) begin
            used_o = target;
        end else begin
            used_o = lookup_hit_i;
        end
    end

endmodule

// File: source/tlb_top.sv
/*
 * Sixteen-entry fully associative TLB with pseudo LRU refill.
 * Lookups answer one cycle after the strobe; fills and flush are plain strobes.
 */
module tlb_top (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  tlb_pkg::lookup_req_t lookup_i,
    input  tlb_pkg::fill_req_t   fill_i,
    input  logic                 flush_i,
    output tlb_pkg::lookup_rsp_t lookup_o
);

    // store to selector
    logic [tlb_pkg::TlbEntries-1:0] valid;
    logic [tlb_pkg::TlbEntries-1:0] fill_match;
    logic [tlb_pkg::TlbEntries-1:0] lookup_hit;

    // selector to store
    logic [tlb_pkg::TlbEntries-1:0] write_en;

    // selector and tree
    logic [tlb_pkg::TlbEntries-1:0] used;
    logic [tlb_pkg::TlbEntries-1:0] plru;

    // entries, compare and registered response
    tlb_entry_store i_entry_store (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .lookup_i     (lookup_i),
        .fill_i       (fill_i),
        .flush_i      (flush_i),
        .write_en_i   (write_en),
        .valid_o      (valid),
        .fill_match_o (fill_match),
        .lookup_hit_o (lookup_hit),
        .lookup_o     (lookup_o)
    );

    // fill target and use vector
    tlb_victim_sel i_victim_sel (
        .fill_valid_i (fill_i.valid),
        .flush_i      (flush_i),
        .valid_i      (valid),
        .fill_match_i (fill_match),
        .lookup_hit_i (lookup_hit),
        .plru_i       (plru),
        .write_en_o   (write_en),
        .used_o       (used)
    );

    // replacement state, updated at the same edge as the access
    plru_tree #(
        .ENTRIES (tlb_pkg::TlbEntries)
    ) i_plru_tree (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .used_i (used),
        .plru_o (plru)
    );

endmodule

// File: test/tb_clock_gen.sv
/*
 * Testbench clock and reset source, 8 ns period.
 * Reset is held low for two rising edges and released on a falling edge.
 */
module tb_clock_gen (
    output logic clk_o,
    output logic rst_no
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam time HalfPeriod = 4ns;

    initial begin
        clk_o = 1'b0;
        forever #HalfPeriod clk_o = ~clk_o;
    end

    // release away from the rising edge
    initial begin
        rst_no = 1'b0;
        repeat (2) @(posedge clk_o);
        @(negedge clk_o);
        rst_no = 1'b1;
    end

endmodule

// File: test/tb_tlb_top.sv
/*
 * Testbench of the TLB: directed and random traffic against a reference model.
 * Concurrent assertions check every response; the run stops at the first error.
 */
module tb_tlb_top;
    timeunit 1ns;
    timeprecision 1ps;

    typedef logic [tlb_pkg::VpnWidth-1:0] vpn_t;
    typedef logic [tlb_pkg::PpnWidth-1:0] ppn_t;

    localparam int Entries      = tlb_pkg::TlbEntries;
    localparam int TreeDepth    = tlb_pkg::TlbIdxWidth;
    localparam int RandomCycles = 1500;
    // directed part is about 120 cycles, limit is a little over twice the whole run
    localparam int MaxCycles    = 4000;

    logic                 clk_i;
    logic                 rst_ni;
    tlb_pkg::lookup_req_t lookup_req;
    tlb_pkg::fill_req_t   fill_req;
    logic                 flush;
    tlb_pkg::lookup_rsp_t lookup_rsp;

    // model answer for the strobe driven in this cycle
    logic exp_hit;
    ppn_t exp_ppn;

    // reference model, entries plus one bit per inner tree node
    logic m_valid [Entries];
    vpn_t m_vpn   [Entries];
    ppn_t m_ppn   [Entries];
    logic m_tree  [Entries-1];

    logic [31:0] rng_state = 32'h09ec_97b9;
    int          cycle_count = 0;

    tb_clock_gen i_clock_gen (
        .clk_o  (clk_i),
        .rst_no (rst_ni)
    );

    tlb_top i_dut (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .lookup_i (lookup_req),
        .fill_i   (fill_req),
        .flush_i  (flush),
        .lookup_o (lookup_rsp)
    );

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // every strobe answered one cycle later with the model value taken at issue
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        lookup_req.valid |=> lookup_rsp.valid && (lookup_rsp.hit == $past(exp_hit))
            && (!$past(exp_hit) || (lookup_rsp.ppn == $past(exp_ppn))))
        else abort_run($sformatf("ERR %0t: lookup response differs from the model", $time));

    // no answer without a strobe the cycle before
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        lookup_rsp.valid |-> $past(lookup_req.valid))
        else abort_run($sformatf("ERR %0t: response without a lookup strobe", $time));

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot(i_dut.i_plru_tree.plru_o))
        else abort_run($sformatf("ERR %0t: PLRU candidate is not one-hot", $time));

    // cycle limit
    always @(posedge clk_i) begin
        if (rst_ni) begin
            cycle_count++;
            if (cycle_count >= MaxCycles) begin
                abort_run("timeout: the run went past its cycle limit without finishing");
            end
        end
    end

    function automatic logic [31:0] rand_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // distinct directed pages and a small random pool
    function automatic vpn_t page_of(input int k);
        return vpn_t'(20'h4_0000 + k * 20'h0_0131);
    endfunction

    function automatic vpn_t pool_page(input logic [15:0] r);
        return vpn_t'(20'h0_8000 + (r % 24));
    endfunction

    function automatic int find_page(input vpn_t vpn);
        for (int i = 0; i < Entries; i++) begin
            if (m_valid[i] && m_vpn[i] == vpn) return i;
        end
        return -1;
    endfunction

    // walk from the root, each node points away from the used branch
    function automatic void tree_touch(input int idx);
        int node;
        int dir;
        node = 0;
        for (int lvl = TreeDepth - 1; lvl >= 0; lvl--) begin
            dir          = (idx >> lvl) & 1;
            m_tree[node] = (dir == 0);
            node         = 2 * node + 1 + dir;
        end
    endfunction

    // follow the node bits down to the candidate leaf
    function automatic int tree_victim();
        int node;
        int idx;
        int dir;
        node = 0;
        idx  = 0;
        for (int lvl = 0; lvl < TreeDepth; lvl++) begin
            dir  = m_tree[node] ? 1 : 0;
            idx  = 2 * idx + dir;
            node = 2 * node + 1 + dir;
        end
        return idx;
    endfunction

    function automatic int pick_target(input vpn_t vpn);
        int idx;
        idx = find_page(vpn);
        if (idx >= 0) return idx;
        for (int i = 0; i < Entries; i++) begin
            if (!m_valid[i]) return i;
        end
        return tree_victim();
    endfunction

    // one clock: drive on the falling edge, predict, then advance the model
    task automatic step_cycle(input logic lk_v, input vpn_t lk_vpn, input logic f_v,
                              input vpn_t f_vpn, input ppn_t f_ppn, input logic fl);
        int hit_idx;
        int tgt;
        @(negedge clk_i);
        lookup_req = '{valid: lk_v, vpn: lk_vpn};
        fill_req   = '{valid: f_v, vpn: f_vpn, ppn: f_ppn};
        flush      = fl;
        hit_idx    = find_page(lk_vpn);
        exp_hit    = lk_v && (hit_idx >= 0);
        exp_ppn    = (hit_idx >= 0) ? m_ppn[hit_idx] : '0;
        if (fl) begin
            for (int i = 0; i < Entries; i++) m_valid[i] = 1'b0;
        end else if (f_v) begin
            tgt          = pick_target(f_vpn);
            m_valid[tgt] = 1'b1;
            m_vpn[tgt]   = f_vpn;
            m_ppn[tgt]   = f_ppn;
            tree_touch(tgt);
        end else if (exp_hit) begin
            tree_touch(hit_idx);
        end
    endtask

    task automatic issue_lookup(input vpn_t vpn);
        step_cycle(1'b1, vpn, 1'b0, '0, '0, 1'b0);
    endtask

    task automatic write_fill(input vpn_t vpn, input ppn_t ppn);
        step_cycle(1'b0, '0, 1'b1, vpn, ppn, 1'b0);
    endtask

    task automatic idle_cycle();
        step_cycle(1'b0, '0, 1'b0, '0, '0, 1'b0);
    endtask

    initial begin
        logic [31:0] r_ctl;
        logic [31:0] r_lk;
        logic [31:0] r_fill;
        int          touch_order [7];
        lookup_req = '0;
        fill_req   = '0;
        flush      = 1'b0;
        exp_hit    = 1'b0;
        exp_ppn    = '0;
        for (int i = 0; i < Entries; i++) begin
            m_valid[i] = 1'b0;
            m_vpn[i]   = '0;
            m_ppn[i]   = '0;
        end
        for (int i = 0; i < Entries - 1; i++) m_tree[i] = 1'b0;
        touch_order = '{3, 7, 11, 0, 15, 5, 9};
        wait (rst_ni === 1'b1);

        // empty buffer misses, gaps between strobes
        for (int k = 0; k < 6; k++) begin
            issue_lookup(vpn_t'(rand_next() >> 12));
            idle_cycle();
        end
        // partial fill from entry 0 upward
        for (int k = 0; k < 6; k++) write_fill(page_of(k), ppn_t'(rand_next() >> 10));
        for (int k = 0; k < 6; k++) issue_lookup(page_of(k));
        // same page again, overwritten in place
        write_fill(page_of(2), ppn_t'(rand_next() >> 10));
        for (int k = 0; k < 6; k++) issue_lookup(page_of(k));

        // fill up, touch a pattern, then evict
        for (int k = 6; k < Entries; k++) write_fill(page_of(k), ppn_t'(rand_next() >> 10));
        foreach (touch_order[j]) issue_lookup(page_of(touch_order[j]));
        write_fill(page_of(16), ppn_t'(rand_next() >> 10));
        for (int k = 0; k <= 16; k++) issue_lookup(page_of(k));
        write_fill(page_of(17), ppn_t'(rand_next() >> 10));
        for (int k = 0; k <= 17; k++) issue_lookup(page_of(k));

        // flush, then refill from entry 0
        step_cycle(1'b0, '0, 1'b0, '0, '0, 1'b1);
        for (int k = 0; k <= 17; k++) issue_lookup(page_of(k));
        for (int k = 20; k < 25; k++) write_fill(page_of(k), ppn_t'(rand_next() >> 10));
        for (int k = 20; k < 25; k++) issue_lookup(page_of(k));
        // fill and lookup of one page together, the lookup sees the old contents
        step_cycle(1'b1, page_of(30), 1'b1, page_of(30), ppn_t'(rand_next() >> 10), 1'b0);
        issue_lookup(page_of(30));

        // random mix over a small page pool so hits and evictions happen
        for (int n = 0; n < RandomCycles; n++) begin
            r_ctl  = rand_next();
            r_lk   = rand_next();
            r_fill = rand_next();
            step_cycle(r_ctl[31:30] != 2'b00, pool_page(r_lk[31:16]), r_ctl[29:28] == 2'b00,
                       pool_page(r_fill[31:16]), ppn_t'(r_fill >> 8), r_ctl[27:21] == 7'd0);
        end
        repeat (3) idle_cycle();

        $display(">>> PASS");
        $finish;
    end

endmodule

// File: sim.f
source/tlb_pkg.sv
source/plru_tree.sv
source/tlb_entry_store.sv
source/tlb_victim_sel.sv
source/tlb_top.sv
test/tb_clock_gen.sv
test/tb_tlb_top.sv
